// File: apb_uart_bridge.sv
// APB bridge toward the UART
`default_nettype none

module apb_uart_bridge (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Bus side
  input  logic                    req_i,
  input  logic                    we_i,
  input  mini_soc_pkg::addr_t     addr_i,
  input  mini_soc_pkg::data_t     wdata_i,
  output logic                    valid_o,
  output logic                    err_o,
  output mini_soc_pkg::data_t     rdata_o,
  // APB side
  output logic                    uart_psel_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output mini_soc_pkg::addr_t     uart_paddr_o,
  output mini_soc_pkg::apb_data_t uart_pwdata_o,
  input  mini_soc_pkg::apb_data_t uart_prdata_i,
  input  logic                    uart_pready_i,
  input  logic                    uart_pslverr_i
);

  typedef enum logic [1:0] {
    StIdle,
    StSetup,
    StAccess
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  mini_soc_pkg::addr_t     paddr_q;
  mini_soc_pkg::apb_data_t pwdata_q;
  logic                    pwrite_q;
  logic                    valid_q;
  logic                    err_q;
  mini_soc_pkg::data_t     rdata_q;
  logic                    done;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////////////////////////////////////////

  // Access phase completes when the UART is ready
  assign done = (state_q == StAccess) && uart_pready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (req_i) begin
          state_d = StSetup;
        end
      end
      StSetup: begin
        state_d = StAccess;
      end
      StAccess: begin
        if (uart_pready_i) begin
          state_d = StIdle;
        end
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StIdle;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= done;
      err_q   <= done && uart_pslverr_i;
    end
  end

  // Request capture and read data
  always_ff @(posedge clk_i) begin
    if (req_i && (state_q == StIdle)) begin
      paddr_q  <= addr_i - mini_soc_pkg::UartBase;
      pwrite_q <= we_i;
      pwdata_q <= wdata_i[$bits(mini_soc_pkg::apb_data_t)-1:0];
    end
    if (done) begin
      rdata_q <= (pwrite_q || uart_pslverr_i) ? '0 : mini_soc_pkg::data_t'(uart_prdata_i);
    end
  end

  assign uart_psel_o    = state_q != StIdle;
  assign uart_penable_o = state_q == StAccess;
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;

  assign valid_o = valid_q;
  assign err_o   = err_q;
  assign rdata_o = rdata_q;

  // One outstanding request from the master
  a_req_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |-> (state_q == StIdle))
    else $error("UART request while a transfer is in flight");

  a_penable_psel: assert property (@(posedge clk_i) disable iff (reset_i)
    uart_penable_o |-> (uart_psel_o && $past(uart_psel_o)))
    else $error("penable without a preceding setup phase");

endmodule : apb_uart_bridge

`default_nettype wire

// File: ctrl_registers.sv
// SoC control registers
`default_nettype none

module ctrl_registers (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mini_soc_pkg::addr_t addr_i,
  input  mini_soc_pkg::strb_t be_i,
  input  mini_soc_pkg::data_t wdata_i,
  output logic                valid_o,
  output logic                err_o,
  output mini_soc_pkg::data_t rdata_o,
  output mini_soc_pkg::data_t exit_o,
  output mini_soc_pkg::data_t hw_cnt_en_o
);

  mini_soc_pkg::addr_t offset;
  mini_soc_pkg::data_t rd_val;
  logic                acc_err;
  logic                wr_exit;
  logic                wr_cnt_en;
  mini_soc_pkg::data_t exit_q;
  mini_soc_pkg::data_t hw_cnt_en_q;
  mini_soc_pkg::data_t rdata_q;
  logic                valid_q;
  logic                err_q;

  function automatic mini_soc_pkg::data_t be_merge(mini_soc_pkg::data_t old_val,
                                                   mini_soc_pkg::data_t new_val,
                                                   mini_soc_pkg::strb_t be);
    mini_soc_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < $bits(mini_soc_pkg::strb_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset = addr_i - mini_soc_pkg::CtrlBase;

  // Register select
  always_comb begin
    rd_val  = '0;
    acc_err = 1'b0;
    case (offset)
      mini_soc_pkg::CtrlExitOffset:     rd_val = exit_q;
      mini_soc_pkg::CtrlHwCntEnOffset:  rd_val = hw_cnt_en_q;
      mini_soc_pkg::CtrlDramBaseOffset: begin
        rd_val  = mini_soc_pkg::data_t'(mini_soc_pkg::DramBase);
        acc_err = we_i;
      end
      mini_soc_pkg::CtrlDramEndOffset: begin
        rd_val  = mini_soc_pkg::data_t'(mini_soc_pkg::DramBase)
                + mini_soc_pkg::data_t'(mini_soc_pkg::DramLength);
        acc_err = we_i;
      end
      default: acc_err = 1'b1;
    endcase
  end

  assign wr_exit   = req_i && we_i && (offset == mini_soc_pkg::CtrlExitOffset);
  assign wr_cnt_en = req_i && we_i && (offset == mini_soc_pkg::CtrlHwCntEnOffset);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
      valid_q     <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      valid_q <= req_i;
      err_q   <= req_i && acc_err;
      if (wr_exit) begin
        exit_q <= be_merge(exit_q, wdata_i, be_i);
      end
      if (wr_cnt_en) begin
        hw_cnt_en_q <= be_merge(hw_cnt_en_q, wdata_i, be_i);
      end
    end
  end

  // Writes and errors answer with zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= (we_i || acc_err) ? '0 : rd_val;
    end
  end

  assign valid_o     = valid_q;
  assign err_o       = err_q;
  assign rdata_o     = rdata_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule : ctrl_registers

`default_nettype wire

// File: l2_mem.sv
// L2 memory
`default_nettype none

module l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                clk_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mini_soc_pkg::addr_t addr_i,
  input  mini_soc_pkg::strb_t be_i,
  input  mini_soc_pkg::data_t wdata_i,
  output logic                valid_o,
  output mini_soc_pkg::data_t rdata_o
);

  localparam int unsigned IdxWidth = $clog2(L2NumWords);
  localparam int unsigned OffWidth = mini_soc_pkg::ByteOffsetBits;

  mini_soc_pkg::data_t mem_q [L2NumWords];
  logic [IdxWidth-1:0] idx;
  logic                valid_q;
  mini_soc_pkg::data_t rdata_q;

  if (L2NumWords != (1 << IdxWidth)) begin : g_depth_check
    $error("L2NumWords must be a power of two");
  end

  // Word index above the byte offset
  assign idx = addr_i[OffWidth +: IdxWidth];

  always_ff @(posedge clk_i) begin
    valid_q <= req_i;
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(mini_soc_pkg::strb_t); b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign valid_o = valid_q;
  assign rdata_o = rdata_q;

  // Decoder must keep out-of-depth accesses away
  a_idx_in_range: assert property (@(posedge clk_i)
    req_i |-> ((addr_i - mini_soc_pkg::DramBase) >> OffWidth) < L2NumWords)
    else $error("L2 access beyond implemented depth");

endmodule : l2_mem

`default_nettype wire

// File: mini_soc.f
mini_soc_pkg.sv
soc_addr_decoder.sv
l2_mem.sv
apb_uart_bridge.sv
ctrl_registers.sv
mini_soc.sv
mini_soc_tb.sv

// File: mini_soc.sv
// Mini SoC top level
`default_nettype none

module mini_soc #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Master port
  input  logic                    req_i,
  input  logic                    we_i,
  input  mini_soc_pkg::addr_t     addr_i,
  input  mini_soc_pkg::strb_t     be_i,
  input  mini_soc_pkg::data_t     wdata_i,
  output logic                    rsp_valid_o,
  output logic                    rsp_err_o,
  output mini_soc_pkg::data_t     rsp_rdata_o,
  // Control outputs
  output mini_soc_pkg::data_t     exit_o,
  output mini_soc_pkg::data_t     hw_cnt_en_o,
  // UART APB
  output logic                    uart_psel_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output mini_soc_pkg::addr_t     uart_paddr_o,
  output mini_soc_pkg::apb_data_t uart_pwdata_o,
  input  mini_soc_pkg::apb_data_t uart_prdata_i,
  input  logic                    uart_pready_i,
  input  logic                    uart_pslverr_i
);

  logic                l2_req;
  logic                uart_req;
  logic                ctrl_req;
  logic                l2_valid;
  logic                uart_valid;
  logic                ctrl_valid;
  logic                uart_err;
  logic                ctrl_err;
  mini_soc_pkg::data_t l2_rdata;
  mini_soc_pkg::data_t uart_rdata;
  mini_soc_pkg::data_t ctrl_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  soc_addr_decoder #(
    .L2NumWords(L2NumWords)
  ) i_decoder (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_i       (req_i      ),
    .addr_i      (addr_i     ),
    .l2_req_o    (l2_req     ),
    .uart_req_o  (uart_req   ),
    .ctrl_req_o  (ctrl_req   ),
    .l2_valid_i  (l2_valid   ),
    .uart_valid_i(uart_valid ),
    .ctrl_valid_i(ctrl_valid ),
    .uart_err_i  (uart_err   ),
    .ctrl_err_i  (ctrl_err   ),
    .l2_rdata_i  (l2_rdata   ),
    .uart_rdata_i(uart_rdata ),
    .ctrl_rdata_i(ctrl_rdata ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o  ),
    .rsp_rdata_o (rsp_rdata_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////////////////////

  l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i  (clk_i   ),
    .req_i  (l2_req  ),
    .we_i   (we_i    ),
    .addr_i (addr_i  ),
    .be_i   (be_i    ),
    .wdata_i(wdata_i ),
    .valid_o(l2_valid),
    .rdata_o(l2_rdata)
  );

  apb_uart_bridge i_uart_bridge (
    .clk_i         (clk_i         ),
    .reset_i       (reset_i       ),
    .req_i         (uart_req      ),
    .we_i          (we_i          ),
    .addr_i        (addr_i        ),
    .wdata_i       (wdata_i       ),
    .valid_o       (uart_valid    ),
    .err_o         (uart_err      ),
    .rdata_o       (uart_rdata    ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .be_i       (be_i       ),
    .wdata_i    (wdata_i    ),
    .valid_o    (ctrl_valid ),
    .err_o      (ctrl_err   ),
    .rdata_o    (ctrl_rdata ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule : mini_soc

`default_nettype wire

// File: mini_soc_pkg.sv
// Mini SoC shared definitions
`default_nettype none

package mini_soc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////////////////////////////////////////

  // Byte address on the master port
  typedef logic [31:0] addr_t;

  // Narrow data path
  typedef logic [63:0] data_t;

  // One enable per data byte
  typedef logic [7:0] strb_t;

  // UART side of the APB bridge
  typedef logic [31:0] apb_data_t;

  localparam int unsigned DataBytes = $bits(data_t) / 8;

  // Low address bits that select a byte within a word
  localparam int unsigned ByteOffsetBits = $clog2(DataBytes);

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  // 1 GiB DRAM window, only partly backed by the L2
  localparam addr_t DramBase   = 32'h8000_0000;
  localparam addr_t DramLength = 32'h4000_0000;

  localparam addr_t UartBase   = 32'hC000_0000;
  localparam addr_t UartLength = 32'h0000_1000;

  localparam addr_t CtrlBase   = 32'hD000_0000;
  localparam addr_t CtrlLength = 32'h0000_1000;

  ////////////////////////////////////////////////////////////////////////////
  // Control register offsets
  ////////////////////////////////////////////////////////////////////////////

  localparam addr_t CtrlExitOffset     = 32'h0000_0000;
  localparam addr_t CtrlHwCntEnOffset  = 32'h0000_0008;

  // Read-only DRAM window bounds
  localparam addr_t CtrlDramBaseOffset = 32'h0000_0010;
  localparam addr_t CtrlDramEndOffset  = 32'h0000_0018;

endpackage : mini_soc_pkg

`default_nettype wire

// File: mini_soc_tb.sv
// Mini SoC testbench
`default_nettype none

module mini_soc_tb;

  localparam int unsigned L2Words     = 1024;
  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned MaxRequests = 400;
  localparam int unsigned MaxCycles   = 8;
  localparam int unsigned TestWords   = 16;
  localparam int unsigned NumRandom   = 300;
  localparam mini_soc_pkg::addr_t L2Bytes = L2Words * 8;

  // Unmapped, beyond the L2 depth, just past the UART window, high hole
  localparam mini_soc_pkg::addr_t BadAddr [4] = '{
    32'h0000_1000, mini_soc_pkg::DramBase + L2Bytes,
    mini_soc_pkg::UartBase + mini_soc_pkg::UartLength, 32'hF000_0000};

  logic                    clk_i;
  logic                    reset_i;
  logic                    req_i;
  logic                    we_i;
  mini_soc_pkg::addr_t     addr_i;
  mini_soc_pkg::strb_t     be_i;
  mini_soc_pkg::data_t     wdata_i;
  logic                    rsp_valid_o;
  logic                    rsp_err_o;
  mini_soc_pkg::data_t     rsp_rdata_o;
  mini_soc_pkg::data_t     exit_o;
  mini_soc_pkg::data_t     hw_cnt_en_o;
  logic                    uart_psel_o;
  logic                    uart_penable_o;
  logic                    uart_pwrite_o;
  mini_soc_pkg::addr_t     uart_paddr_o;
  mini_soc_pkg::apb_data_t uart_pwdata_o;
  mini_soc_pkg::apb_data_t uart_prdata_i;
  logic                    uart_pready_i;
  logic                    uart_pslverr_i;

  // Reference shadows
  mini_soc_pkg::data_t     l2_sh [L2Words];
  mini_soc_pkg::apb_data_t uart_sh [4];
  mini_soc_pkg::data_t     exit_sh;
  mini_soc_pkg::data_t     cnt_en_sh;

  // UART registers inside the APB responder
  mini_soc_pkg::apb_data_t uart_dev [4];

  mini_soc #(
    .L2NumWords(L2Words)
  ) mini_soc_i (
    .clk_i         (clk_i         ),
    .reset_i       (reset_i       ),
    .req_i         (req_i         ),
    .we_i          (we_i          ),
    .addr_i        (addr_i        ),
    .be_i          (be_i          ),
    .wdata_i       (wdata_i       ),
    .rsp_valid_o   (rsp_valid_o   ),
    .rsp_err_o     (rsp_err_o     ),
    .rsp_rdata_o   (rsp_rdata_o   ),
    .exit_o        (exit_o        ),
    .hw_cnt_en_o   (hw_cnt_en_o   ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display(">>> FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input mini_soc_pkg::data_t exp,
                            input mini_soc_pkg::data_t act);
    if (exp !== act) begin
      $display("mismatch %s rdata expected %h actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s err expected %b actual %b", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_reg(input string name, input mini_soc_pkg::data_t exp,
                           input mini_soc_pkg::data_t act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic mini_soc_pkg::data_t merge_bytes(input mini_soc_pkg::data_t old_val,
                                                      input mini_soc_pkg::data_t new_val,
                                                      input mini_soc_pkg::strb_t be);
    mini_soc_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic void predict(input logic we, input mini_soc_pkg::addr_t addr,
                                  input mini_soc_pkg::strb_t be,
                                  input mini_soc_pkg::data_t wdata,
                                  output mini_soc_pkg::data_t exp_rdata,
                                  output logic exp_err);
    mini_soc_pkg::addr_t off;
    int                  idx;
    exp_rdata = '0;
    exp_err   = 1'b0;
    if ((addr - mini_soc_pkg::DramBase) < mini_soc_pkg::DramLength) begin
      off = addr - mini_soc_pkg::DramBase;
      idx = int'(off >> 3);
      if (off >= L2Bytes) begin
        exp_err = 1'b1;
      end else if (we) begin
        l2_sh[idx] = merge_bytes(l2_sh[idx], wdata, be);
      end else begin
        exp_rdata = l2_sh[idx];
      end
    end else if ((addr - mini_soc_pkg::UartBase) < mini_soc_pkg::UartLength) begin
      off = addr - mini_soc_pkg::UartBase;
      if (off >= 32'h10) begin
        exp_err = 1'b1;
      end else if (we) begin
        uart_sh[off[3:2]] = wdata[31:0];
      end else begin
        exp_rdata = {32'h0, uart_sh[off[3:2]]};
      end
    end else if ((addr - mini_soc_pkg::CtrlBase) < mini_soc_pkg::CtrlLength) begin
      off = addr - mini_soc_pkg::CtrlBase;
      case (off)
        mini_soc_pkg::CtrlExitOffset: begin
          if (we) exit_sh = merge_bytes(exit_sh, wdata, be);
          else exp_rdata = exit_sh;
        end
        mini_soc_pkg::CtrlHwCntEnOffset: begin
          if (we) cnt_en_sh = merge_bytes(cnt_en_sh, wdata, be);
          else exp_rdata = cnt_en_sh;
        end
        mini_soc_pkg::CtrlDramBaseOffset: begin
          if (we) exp_err = 1'b1;
          else exp_rdata = {32'h0, mini_soc_pkg::DramBase};
        end
        mini_soc_pkg::CtrlDramEndOffset: begin
          if (we) exp_err = 1'b1;
          else exp_rdata = {32'h0, mini_soc_pkg::DramBase}
                         + {32'h0, mini_soc_pkg::DramLength};
        end
        default: exp_err = 1'b1;
      endcase
    end else begin
      exp_err = 1'b1;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Master driver
  ////////////////////////////////////////////////////////////////////////////

  function automatic mini_soc_pkg::data_t random_data();
    return {$urandom, $urandom};
  endfunction

  function automatic mini_soc_pkg::addr_t random_addr();
    case ($urandom_range(3, 0))
      0: return mini_soc_pkg::DramBase + 32'($urandom_range(TestWords - 1, 0) * 8);
      1: return mini_soc_pkg::UartBase + 32'($urandom_range(4, 0) * 4);
      2: return mini_soc_pkg::CtrlBase + 32'($urandom_range(5, 0) * 8);
      default: return BadAddr[$urandom_range(3, 0)];
    endcase
  endfunction

  // Entered and left 1 time unit after a rising edge
  task automatic do_request(input string name, input logic we,
                            input mini_soc_pkg::addr_t addr,
                            input mini_soc_pkg::strb_t be,
                            input mini_soc_pkg::data_t wdata);
    mini_soc_pkg::data_t exp_rdata;
    logic                exp_err;
    logic                is_uart;
    int                  cycles;
    predict(we, addr, be, wdata, exp_rdata, exp_err);
    is_uart = (addr - mini_soc_pkg::UartBase) < mini_soc_pkg::UartLength;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    @(posedge clk_i);
    #1;
    req_i  = 1'b0;
    cycles = 1;
    while (!rsp_valid_o) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!is_uart && cycles != 1) begin
      $display("mismatch %s latency expected 1 actual %0d", name, cycles);
      stop_on_failure();
    end
    check_err(name, exp_err, rsp_err_o);
    check_data(name, exp_rdata, rsp_rdata_o);
    check_reg({name, " exit_o"}, exit_sh, exit_o);
    check_reg({name, " hw_cnt_en_o"}, cnt_en_sh, hw_cnt_en_o);
    @(posedge clk_i);
    #1;
    // One response pulse per request
    if (rsp_valid_o) begin
      $display("rsp_valid_o stayed high for more than one cycle in %s", name);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB UART responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin : apb_responder
    int unsigned waits;
    logic        in_access;
    in_access      = 1'b0;
    waits          = 0;
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      uart_dev[i] = '0;
    end
    forever begin
      @(posedge clk_i);
      #1;
      uart_pready_i  = 1'b0;
      uart_pslverr_i = 1'b0;
      uart_prdata_i  = '0;
      if (uart_psel_o && uart_penable_o) begin
        if (!in_access) begin
          waits     = $urandom_range(3, 0);
          in_access = 1'b1;
        end
        if (waits == 0) begin
          in_access     = 1'b0;
          uart_pready_i = 1'b1;
          if (uart_paddr_o >= 32'h10) begin
            uart_pslverr_i = 1'b1;
          end else if (uart_pwrite_o) begin
            uart_dev[uart_paddr_o[3:2]] = uart_pwdata_o;
          end else begin
            uart_prdata_i = uart_dev[uart_paddr_o[3:2]];
          end
        end else begin
          waits--;
        end
      end
    end
  end

  // Every request plus margin
  initial begin : watchdog
    #(MaxRequests * MaxCycles * ClkPeriod + 200);
    $display("timeout, a response never arrived");
    stop_on_failure();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    mini_soc_pkg::addr_t ctrl_exit;
    mini_soc_pkg::addr_t ctrl_cnt;
    void'($urandom(6583));
    ctrl_exit = mini_soc_pkg::CtrlBase + mini_soc_pkg::CtrlExitOffset;
    ctrl_cnt  = mini_soc_pkg::CtrlBase + mini_soc_pkg::CtrlHwCntEnOffset;
    reset_i   = 1'b1;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    be_i      = '0;
    wdata_i   = '0;
    exit_sh   = '0;
    cnt_en_sh = '0;
    for (int i = 0; i < 4; i++) begin
      uart_sh[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Quiet after reset
    repeat (3) begin
      check_err("reset rsp_valid_o", 1'b0, rsp_valid_o);
      check_err("reset rsp_err_o", 1'b0, rsp_err_o);
      check_reg("reset exit_o", '0, exit_o);
      check_reg("reset hw_cnt_en_o", '0, hw_cnt_en_o);
      @(posedge clk_i);
      #1;
    end

    // L2 full writes, partial writes, read back
    for (int i = 0; i < TestWords; i++) begin
      do_request("l2 init", 1'b1, mini_soc_pkg::DramBase + 32'(i * 8), 8'hFF, random_data());
    end
    for (int i = 0; i < TestWords; i++) begin
      do_request("l2 partial write", 1'b1, mini_soc_pkg::DramBase + 32'(i * 8),
                 8'($urandom_range(255, 0)), random_data());
    end
    for (int i = 0; i < TestWords; i++) begin
      do_request("l2 read", 1'b0, mini_soc_pkg::DramBase + 32'(i * 8), '0, '0);
    end

    // Control registers
    do_request("ctrl exit write", 1'b1, ctrl_exit, 8'hFF, random_data());
    do_request("ctrl exit partial", 1'b1, ctrl_exit, 8'($urandom_range(255, 0)),
               random_data());
    do_request("ctrl exit read", 1'b0, ctrl_exit, '0, '0);
    do_request("ctrl cnt write", 1'b1, ctrl_cnt, 8'hFF, random_data());
    do_request("ctrl cnt partial", 1'b1, ctrl_cnt, 8'h0F, random_data());
    do_request("ctrl cnt read", 1'b0, ctrl_cnt, '0, '0);
    do_request("ctrl dram base read", 1'b0, mini_soc_pkg::CtrlBase + 32'h10, '0, '0);
    do_request("ctrl dram end read", 1'b0, mini_soc_pkg::CtrlBase + 32'h18, '0, '0);
    do_request("ctrl dram base write", 1'b1, mini_soc_pkg::CtrlBase + 32'h10, 8'hFF, '1);
    do_request("ctrl dram end write", 1'b1, mini_soc_pkg::CtrlBase + 32'h18, 8'hFF, '1);
    do_request("ctrl dram base reread", 1'b0, mini_soc_pkg::CtrlBase + 32'h10, '0, '0);
    do_request("ctrl unknown write", 1'b1, mini_soc_pkg::CtrlBase + 32'h4, 8'hFF, '1);
    do_request("ctrl unknown read", 1'b0, mini_soc_pkg::CtrlBase + 32'h100, '0, '0);

    // UART through APB
    for (int i = 0; i < 4; i++) begin
      do_request("uart write", 1'b1, mini_soc_pkg::UartBase + 32'(i * 4), 8'hFF,
                 random_data());
    end
    for (int i = 0; i < 4; i++) begin
      do_request("uart read", 1'b0, mini_soc_pkg::UartBase + 32'(i * 4), '0, '0);
    end
    do_request("uart bad write", 1'b1, mini_soc_pkg::UartBase + 32'h10, 8'hFF, '1);
    do_request("uart bad read", 1'b0, mini_soc_pkg::UartBase + 32'h14, '0, '0);
    do_request("uart far read", 1'b0, mini_soc_pkg::UartBase + 32'h800, '0, '0);

    // Unmapped and out-of-depth accesses leave L2 alone
    for (int i = 0; i < 4; i++) begin
      do_request("unmapped write", 1'b1, BadAddr[i], 8'hFF, random_data());
      do_request("unmapped read", 1'b0, BadAddr[i], '0, '0);
    end
    do_request("l2 after unmapped", 1'b0, mini_soc_pkg::DramBase, '0, '0);

    for (int i = 0; i < NumRandom; i++) begin
      do_request("random mix", 1'($urandom_range(1, 0)), random_addr(),
                 8'($urandom_range(255, 0)), random_data());
    end

    $display(">>> PASS");
    $finish;
  end

endmodule : mini_soc_tb

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the mini_soc simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mini_soc_tb -f mini_soc.f \
    -o mini_soc_sim \
  && ./obj_dir/mini_soc_sim | tee /dev/stderr | grep -q -x ">>> PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: soc_addr_decoder.sv
// Mini SoC address decoder
`default_nettype none

module soc_addr_decoder #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Master request
  input  logic                req_i,
  input  mini_soc_pkg::addr_t addr_i,
  // Target strobes
  output logic                l2_req_o,
  output logic                uart_req_o,
  output logic                ctrl_req_o,
  // Target responses
  input  logic                l2_valid_i,
  input  logic                uart_valid_i,
  input  logic                ctrl_valid_i,
  input  logic                uart_err_i,
  input  logic                ctrl_err_i,
  input  mini_soc_pkg::data_t l2_rdata_i,
  input  mini_soc_pkg::data_t uart_rdata_i,
  input  mini_soc_pkg::data_t ctrl_rdata_i,
  // Master response
  output logic                rsp_valid_o,
  output logic                rsp_err_o,
  output mini_soc_pkg::data_t rsp_rdata_o
);

  // Bytes actually backed by the L2
  localparam mini_soc_pkg::addr_t L2Bytes =
    mini_soc_pkg::addr_t'(L2NumWords * mini_soc_pkg::DataBytes);

  localparam int unsigned TgtL2   = 0;
  localparam int unsigned TgtUart = 1;
  localparam int unsigned TgtCtrl = 2;

  mini_soc_pkg::addr_t dram_off;
  mini_soc_pkg::addr_t uart_off;
  mini_soc_pkg::addr_t ctrl_off;
  logic                l2_hit;
  logic                uart_hit;
  logic                ctrl_hit;
  logic [2:0]          pend_q;
  logic                dec_err_q;
  logic [2:0]          tgt_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////////////////////

  // Offsets wrap below the base, so one compare covers both bounds
  assign dram_off = addr_i - mini_soc_pkg::DramBase;
  assign uart_off = addr_i - mini_soc_pkg::UartBase;
  assign ctrl_off = addr_i - mini_soc_pkg::CtrlBase;

  assign l2_hit   = (dram_off < mini_soc_pkg::DramLength) && (dram_off < L2Bytes);
  assign uart_hit = uart_off < mini_soc_pkg::UartLength;
  assign ctrl_hit = ctrl_off < mini_soc_pkg::CtrlLength;

  assign l2_req_o   = req_i && l2_hit;
  assign uart_req_o = req_i && uart_hit;
  assign ctrl_req_o = req_i && ctrl_hit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q    <= '0;
      dec_err_q <= 1'b0;
    end else begin
      if (req_i) begin
        pend_q <= {ctrl_hit, uart_hit, l2_hit};
      end else if (rsp_valid_o) begin
        pend_q <= '0;
      end
      // Unmapped or beyond the L2 depth
      dec_err_q <= req_i && !(l2_hit || uart_hit || ctrl_hit);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////////////////////

  assign tgt_valid = {ctrl_valid_i, uart_valid_i, l2_valid_i} & pend_q;

  assign rsp_valid_o = (|tgt_valid) || dec_err_q;
  assign rsp_err_o   = dec_err_q
                    || (tgt_valid[TgtUart] && uart_err_i)
                    || (tgt_valid[TgtCtrl] && ctrl_err_i);

  // Own error response falls through to zero
  always_comb begin
    rsp_rdata_o = '0;
    if (pend_q[TgtL2]) begin
      rsp_rdata_o = l2_rdata_i;
    end else if (pend_q[TgtUart]) begin
      rsp_rdata_o = uart_rdata_i;
    end else if (pend_q[TgtCtrl]) begin
      rsp_rdata_o = ctrl_rdata_i;
    end
  end

  a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({l2_req_o, uart_req_o, ctrl_req_o}))
    else $error("more than one target strobe");

  // A target may only answer the request it was given
  a_valid_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    ({ctrl_valid_i, uart_valid_i, l2_valid_i} & ~pend_q) == 3'b000)
    else $error("target response without pending request");

endmodule : soc_addr_decoder

`default_nettype wire
